//--- compile.f
mutative_types.sv
way_bus_if.sv
host_write_port.sv
way_store.sv
mutative_control.sv
writeback_port.sv
mutative_flush_top.sv
tb_mutative_flush.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_mutative_flush -o sim_tb &&
out=$(./obj_dir/sim_tb) &&
echo "$out" &&
echo "$out" | grep -qx "No errors" ||
{ echo "Simulation failed"; exit 1; }

//--- tb_mutative_flush.sv
`timescale 1ns/100ps

module tb_mutative_flush;

    localparam int WAYS          = mutative_types::WAYS;
    localparam int SET_SIZE      = mutative_types::SET_SIZE;
    localparam int SET_BITS      = mutative_types::SET_BITS;
    localparam int OFFSET_BITS   = mutative_types::OFFSET_BITS;
    localparam int TAG_BITS      = mutative_types::TAG_BITS;
    localparam int CLK_PERIOD    = 20;
    localparam int RANDOM_WRITES = 40;
    localparam int LINES         = RANDOM_WRITES + 2 * WAYS;
    localparam int SETUPS        = 9;
    // Pick, request, up to four cycles of memory delay, done and clean
    localparam int WB_WORST      = 10;
    localparam int READY_LIMIT   = SET_SIZE * 4 + LINES * WB_WORST;
    localparam int WATCHDOG_CYCLES = LINES * (WB_WORST + 2) + SETUPS * (SET_SIZE * 3 + 8) + 50;

    logic                      clk;
    logic                      rst;
    logic                      host_wr;
    mutative_types::set_addr_t host_set;
    mutative_types::way_idx_t  host_way;
    mutative_types::tag_t      host_tag;
    mutative_types::line_t     host_data;
    logic                      host_accept;
    logic                      setup_valid;
    logic                      setup_update;
    logic                      setup_ready;
    mutative_types::setup_t    setup_level;
    mutative_types::way_mask_t active_ways;
    logic                      flush_stall;
    logic                      dfp_write;
    mutative_types::mem_addr_t dfp_addr;
    mutative_types::line_t     dfp_wdata;
    logic                      dfp_resp;

    // Lines expected to come back as write-backs
    logic                      exp_dirty [SET_SIZE][WAYS];
    mutative_types::tag_t      exp_tag   [SET_SIZE][WAYS];
    mutative_types::line_t     exp_data  [SET_SIZE][WAYS];
    mutative_types::setup_t    model_level;

    logic [31:0]               stim_rng;
    logic [31:0]               resp_rng;
    int                        errors   = 0;
    int                        checks   = 0;
    int                        wb_count = 0;

    mutative_flush_top #(.WAYS(WAYS), .SET_SIZE(SET_SIZE)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Ways 0 up to 2**level are switched on
    function automatic mutative_types::way_mask_t mask_for_level(
        input mutative_types::setup_t level
    );
        int count;
        count = 2 ** int'(level);
        if (count > WAYS) begin
            count = WAYS;
        end
        return mutative_types::way_mask_t'((1 << count) - 1);
    endfunction

    function automatic int count_dirty();
        int n;
        n = 0;
        for (int s = 0; s < SET_SIZE; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                if (exp_dirty[s][w]) begin
                    n++;
                end
            end
        end
        return n;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic host_write(input int set_idx, input int way_idx);
        mutative_types::way_mask_t mask;
        mutative_types::tag_t      tag;
        mutative_types::line_t     data;
        logic                      expect_accept;
        stim_rng = lcg(stim_rng);
        tag = stim_rng[31:9];
        for (int i = 0; i < 8; i++) begin
            stim_rng = lcg(stim_rng);
            data[i*32 +: 32] = stim_rng;
        end
        mask = mask_for_level(model_level);
        expect_accept = mask[way_idx];
        host_wr   = 1'b1;
        host_set  = mutative_types::set_addr_t'(set_idx);
        host_way  = mutative_types::way_idx_t'(way_idx);
        host_tag  = tag;
        host_data = data;
        #1;
        check_eq("host_accept", expect_accept, host_accept);
        if (expect_accept) begin
            exp_dirty[set_idx][way_idx] = 1'b1;
            exp_tag[set_idx][way_idx]   = tag;
            exp_data[set_idx][way_idx]  = data;
        end
        @(posedge clk);
        #2;
        host_wr = 1'b0;
    endtask

    task automatic change_level(input logic up);
        mutative_types::setup_t expected;
        int                     waited;
        if (up) begin
            expected = (model_level == 2'd3) ? 2'd3 : model_level + 2'd1;
        end else begin
            expected = (model_level == 2'd0) ? 2'd0 : model_level - 2'd1;
        end
        waited       = 0;
        host_way     = '0;
        setup_valid  = 1'b1;
        setup_update = up;
        #1;
        check_eq("flush_stall at request", !up, flush_stall);
        while (!setup_ready && waited < READY_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
            check_eq("level before ready", model_level, setup_level);
            if (!up) begin
                checks++;
                assert (flush_stall && !host_accept) else begin
                    errors++;
                    $display("Host port open or stall low in the middle of a flush");
                end
            end
        end
        checks++;
        assert (setup_ready) else begin
            errors++;
            $display("setup_ready did not rise within %0d cycles", READY_LIMIT);
        end
        if (!setup_ready) begin
            #1;
            setup_valid = 1'b0;
        end else begin
            if (up) begin
                check_eq("increment ready latency", 1, waited);
            end
            @(posedge clk);
            #2;
            setup_valid = 1'b0;
            check_eq("setup_level", expected, setup_level);
            check_eq("setup_ready after handshake", 0, setup_ready);
            check_eq("active_ways", mask_for_level(expected), active_ways);
            model_level = expected;
        end
    endtask

    task automatic flush_and_check(input string name);
        int expected_wbs;
        int start_count;
        expected_wbs = count_dirty();
        start_count  = wb_count;
        change_level(1'b0);
        check_eq({name, " write-backs"}, expected_wbs, wb_count - start_count);
        check_eq({name, " lines left dirty"}, 0, count_dirty());
        check_eq({name, " dfp_write idle"}, 0, dfp_write);
    endtask

    // Address is tag, set, zero offset
    task automatic match_writeback(input mutative_types::mem_addr_t addr,
                                   input mutative_types::line_t data);
        int set_idx;
        int hit;
        set_idx = int'(addr[OFFSET_BITS +: SET_BITS]);
        hit     = -1;
        wb_count++;
        check_eq("write-back offset bits", 0, addr[OFFSET_BITS-1:0]);
        for (int w = 0; w < WAYS; w++) begin
            if (exp_dirty[set_idx][w] && exp_tag[set_idx][w] == addr[31 -: TAG_BITS]) begin
                hit = w;
            end
        end
        checks++;
        assert (hit >= 0) else begin
            errors++;
            $display("Write-back to %h matches no dirty line or repeats one", addr);
        end
        if (hit >= 0) begin
            assert (data == exp_data[set_idx][hit]) else begin
                errors++;
                $display("Mismatch write-back data at %h: expected %h, actual %h",
                         addr, exp_data[set_idx][hit], data);
            end
            exp_dirty[set_idx][hit] = 1'b0;
        end
    endtask

    initial begin : memory_responder
        mutative_types::mem_addr_t got_addr;
        mutative_types::line_t     got_data;
        int                        delay;
        dfp_resp = 1'b0;
        resp_rng = 32'hdb59;
        forever begin
            @(posedge clk);
            #1;
            if (dfp_write) begin
                got_addr = dfp_addr;
                got_data = dfp_wdata;
                match_writeback(got_addr, got_data);
                resp_rng = lcg(resp_rng);
                delay = 1 + int'((resp_rng >> 16) % 4);
                for (int i = 1; i < delay; i++) begin
                    @(posedge clk);
                    #1;
                    checks++;
                    assert (dfp_write && dfp_addr == got_addr && dfp_wdata == got_data) else begin
                        errors++;
                        $display("Memory request dropped or changed before dfp_resp");
                    end
                end
                #1;
                dfp_resp = 1'b1;
                @(posedge clk);
                #2;
                dfp_resp = 1'b0;
            end
        end
    end

    initial begin : stimulus
        rst          = 1'b1;
        host_wr      = 1'b0;
        host_set     = '0;
        host_way     = '0;
        host_tag     = '0;
        host_data    = '0;
        setup_valid  = 1'b0;
        setup_update = 1'b0;
        stim_rng     = 32'hdb59;
        model_level  = '0;
        for (int s = 0; s < SET_SIZE; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                exp_dirty[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        check_eq("level after reset", 0, setup_level);
        check_eq("active_ways after reset", mask_for_level(2'd0), active_ways);
        check_eq("flush_stall after reset", 0, flush_stall);
        check_eq("setup_ready after reset", 0, setup_ready);
        check_eq("dfp_write after reset", 0, dfp_write);

        // One way on, then two
        for (int w = 0; w < WAYS; w++) begin
            host_write(w, w);
        end
        change_level(1'b1);
        for (int w = 0; w < WAYS; w++) begin
            host_write(w + WAYS, w);
        end
        repeat (3) change_level(1'b1);

        for (int n = 0; n < RANDOM_WRITES; n++) begin
            stim_rng = lcg(stim_rng);
            host_write(int'((stim_rng >> 16) % SET_SIZE), int'((stim_rng >> 24) % WAYS));
        end

        flush_and_check("first flush");
        flush_and_check("second flush");
        flush_and_check("third flush");
        flush_and_check("flush at level 0");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout, run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

//--- mutative_flush_top.sv
`timescale 1ns/100ps

module mutative_flush_top #(
    parameter int WAYS     = mutative_types::WAYS,
    parameter int SET_SIZE = mutative_types::SET_SIZE
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      host_wr,
    input  mutative_types::set_addr_t host_set,
    input  mutative_types::way_idx_t  host_way,
    input  mutative_types::tag_t      host_tag,
    input  mutative_types::line_t     host_data,
    output logic                      host_accept,

    input  logic                      setup_valid,
    input  logic                      setup_update,
    output logic                      setup_ready,
    output mutative_types::setup_t    setup_level,
    output mutative_types::way_mask_t active_ways,
    output logic                      flush_stall,

    output logic                      dfp_write,
    output mutative_types::mem_addr_t dfp_addr,
    output mutative_types::line_t     dfp_wdata,
    input  logic                      dfp_resp
);

    logic                      wr_en;
    mutative_types::set_addr_t wr_set;
    mutative_types::way_idx_t  wr_way;
    mutative_types::tag_t      wr_tag;
    mutative_types::line_t     wr_data;

    logic                      wb_req;
    mutative_types::mem_addr_t wb_addr;
    mutative_types::line_t     wb_wdata;
    logic                      wb_done;

    way_bus_if #(.WAYS(WAYS), .SET_SIZE(SET_SIZE)) bus ();

    host_write_port u_host (
        .clk         (clk),
        .rst         (rst),
        .host_wr     (host_wr),
        .host_set    (host_set),
        .host_way    (host_way),
        .host_tag    (host_tag),
        .host_data   (host_data),
        .flush_stall (flush_stall),
        .active_ways (active_ways),
        .host_accept (host_accept),
        .wr_en       (wr_en),
        .wr_set      (wr_set),
        .wr_way      (wr_way),
        .wr_tag      (wr_tag),
        .wr_data     (wr_data)
    );

    way_store #(.WAYS(WAYS), .SET_SIZE(SET_SIZE)) u_store (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_set  (wr_set),
        .wr_way  (wr_way),
        .wr_tag  (wr_tag),
        .wr_data (wr_data),
        .bus     (bus.store)
    );

    mutative_control #(.WAYS(WAYS), .SET_SIZE(SET_SIZE)) u_control (
        .clk          (clk),
        .rst          (rst),
        .setup_valid  (setup_valid),
        .setup_update (setup_update),
        .setup_ready  (setup_ready),
        .setup_level  (setup_level),
        .flush_stall  (flush_stall),
        .active_ways  (active_ways),
        .bus          (bus.user),
        .wb_req       (wb_req),
        .wb_addr      (wb_addr),
        .wb_wdata     (wb_wdata),
        .wb_done      (wb_done)
    );

    writeback_port u_wb (
        .clk       (clk),
        .rst       (rst),
        .req       (wb_req),
        .addr      (wb_addr),
        .wdata     (wb_wdata),
        .done      (wb_done),
        .dfp_write (dfp_write),
        .dfp_addr  (dfp_addr),
        .dfp_wdata (dfp_wdata),
        .dfp_resp  (dfp_resp)
    );

endmodule

//--- writeback_port.sv
`timescale 1ns/100ps

module writeback_port (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      req,
    input  mutative_types::mem_addr_t addr,
    input  mutative_types::line_t     wdata,
    output logic                      done,

    output logic                      dfp_write,
    output mutative_types::mem_addr_t dfp_addr,
    output mutative_types::line_t     dfp_wdata,
    input  logic                      dfp_resp
);

    typedef enum logic {
        wb_idle,
        wb_busy
    } wb_state_t;

    wb_state_t state;
    logic      take;

    // Request is still up while done pulses, so skip that cycle
    assign take      = (state == wb_idle) & req & ~done;
    assign dfp_write = (state == wb_busy);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wb_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (take) begin
                state <= wb_busy;
            end else if (state == wb_busy && dfp_resp) begin
                state <= wb_idle;
                done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dfp_addr  <= addr;
            dfp_wdata <= wdata;
        end
    end

endmodule

//--- mutative_control.sv
`timescale 1ns/100ps

module mutative_control #(
    parameter int WAYS     = mutative_types::WAYS,
    parameter int SET_SIZE = mutative_types::SET_SIZE
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      setup_valid,
    input  logic                      setup_update,
    output logic                      setup_ready,
    output mutative_types::setup_t    setup_level,
    output logic                      flush_stall,
    output logic [WAYS-1:0]           active_ways,

    way_bus_if.user                   bus,

    output logic                      wb_req,
    output mutative_types::mem_addr_t wb_addr,
    output mutative_types::line_t     wb_wdata,
    input  logic                      wb_done
);

    localparam int SET_W = $clog2(SET_SIZE);
    localparam int WAY_W = $clog2(WAYS);

    typedef enum logic [1:0] {
        f_idle,   // waiting for setup, starts the walk on a decrement
        f_check,  // vectors of the current set are on the bus
        f_flush,  // pick the next dirty way or move on
        f_wait    // write-back in flight
    } flush_state_t;

    flush_state_t           state;
    flush_state_t           state_next;

    mutative_types::setup_t level_q;
    mutative_types::setup_t level_next;
    logic                   ready_q;
    logic                   ready_next;
    logic                   stall_q;
    logic                   handshake;
    logic                   start_flush;

    logic [SET_W-1:0]       set_q;
    logic [SET_W:0]         set_inc;
    logic                   walk_done;
    logic                   leave_set;

    logic                   rd_en;
    logic [SET_W-1:0]       rd_set;
    logic                   latch;
    logic                   clean;

    logic [WAYS-1:0]        pend_q;
    logic [WAYS-1:0]        pend;
    logic                   any_pend;
    logic [WAY_W-1:0]       pick;
    mutative_types::tag_t   tag_q  [WAYS];
    mutative_types::line_t  data_q [WAYS];

    assign handshake   = setup_valid & ready_q;
    assign start_flush = (state == f_idle) & setup_valid & ~setup_update & ~ready_q;

    always_comb begin
        level_next = level_q;
        if (handshake) begin
            if (setup_update && level_q != 2'd3) begin
                level_next = level_q + 2'd1;
            end else if (!setup_update && level_q != 2'd0) begin
                level_next = level_q - 2'd1;
            end
        end
    end

    // 2**level ways from way 0 up
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            active_ways[i] = (i < (1 << level_q));
        end
    end

    assign setup_ready = ready_q;
    assign setup_level = level_q;
    assign flush_stall = stall_q | start_flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            level_q <= '0;
            ready_q <= 1'b0;
            stall_q <= 1'b0;
        end else begin
            level_q <= level_next;
            ready_q <= ready_next;
            if (start_flush) begin
                stall_q <= 1'b1;
            end else if (handshake) begin
                stall_q <= 1'b0;
            end
        end
    end

    // Valid dirty lines still owed for the current set
    assign pend = (state == f_check) ? (bus.valid_vector & bus.dirty_vector) : pend_q;

    always_comb begin
        any_pend = 1'b0;
        pick     = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (pend[i]) begin
                any_pend = 1'b1;
                pick     = WAY_W'(i);
            end
        end
    end

    assign set_inc   = {1'b0, set_q} + 1'b1;
    assign walk_done = (set_inc == (SET_W + 1)'(SET_SIZE));
    assign leave_set = (state == f_check || state == f_flush) && !any_pend;

    always_comb begin
        state_next = state;
        ready_next = ready_q;
        rd_en      = 1'b0;
        rd_set     = set_q;
        latch      = 1'b0;
        clean      = 1'b0;
        wb_req     = 1'b0;

        case (state)
            f_idle: begin
                if (start_flush) begin
                    rd_en      = 1'b1;
                    state_next = f_check;
                end else if (handshake) begin
                    ready_next = 1'b0;
                end else if (setup_valid && setup_update) begin
                    ready_next = 1'b1;
                end
            end
            f_check: begin
                latch = 1'b1;
                if (any_pend) begin
                    state_next = f_flush;
                end
            end
            f_flush: begin
                if (any_pend) begin
                    state_next = f_wait;
                end
            end
            f_wait: begin
                wb_req = 1'b1;
                if (wb_done) begin
                    clean      = 1'b1;
                    state_next = f_flush;
                end
            end
            default: begin
                state_next = f_idle;
            end
        endcase

        // Set finished, read the next one or end the walk
        if (leave_set) begin
            if (walk_done) begin
                ready_next = 1'b1;
                state_next = f_idle;
            end else begin
                rd_en      = 1'b1;
                rd_set     = set_inc[SET_W-1:0];
                state_next = f_check;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= f_idle;
            set_q  <= '0;
            pend_q <= '0;
        end else begin
            state <= state_next;
            if (leave_set) begin
                set_q <= walk_done ? '0 : set_inc[SET_W-1:0];
            end
            if (latch) begin
                pend_q <= pend;
            end else if (clean) begin
                pend_q[pick] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            tag_q  <= bus.tag_vector;
            data_q <= bus.data_vector;
        end
    end

    assign bus.rd_en     = rd_en;
    assign bus.rd_set    = rd_set;
    assign bus.clean_en  = clean;
    assign bus.clean_set = set_q;
    assign bus.clean_way = pick;

    // Line address is tag, set, zero offset
    assign wb_addr  = mutative_types::mem_addr_t'({tag_q[pick], set_q,
                                                   {mutative_types::OFFSET_BITS{1'b0}}});
    assign wb_wdata = data_q[pick];

endmodule

//--- way_store.sv
`timescale 1ns/100ps

module way_store #(
    parameter int WAYS     = mutative_types::WAYS,
    parameter int SET_SIZE = mutative_types::SET_SIZE
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          wr_en,
    input  logic [$clog2(SET_SIZE)-1:0]   wr_set,
    input  logic [$clog2(WAYS)-1:0]       wr_way,
    input  mutative_types::tag_t          wr_tag,
    input  mutative_types::line_t         wr_data,

    way_bus_if.store                      bus
);

    localparam int WAY_W = $clog2(WAYS);

    mutative_types::tag_t  tag_mem  [WAYS][SET_SIZE];
    mutative_types::line_t data_mem [WAYS][SET_SIZE];
    logic [SET_SIZE-1:0]   valid_mem [WAYS];
    logic [SET_SIZE-1:0]   dirty_mem [WAYS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_set]  <= wr_tag;
            data_mem[wr_way][wr_set] <= wr_data;
        end
    end

    // Host writes and flush cleans never hit the same line
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '{default: '0};
            dirty_mem <= '{default: '0};
        end else begin
            if (bus.clean_en) begin
                dirty_mem[bus.clean_way][bus.clean_set] <= 1'b0;
            end
            if (wr_en) begin
                valid_mem[wr_way][wr_set] <= 1'b1;
                dirty_mem[wr_way][wr_set] <= 1'b1;
            end
        end
    end

    // All ways read at once; a write landing on the same edge is forwarded
    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                if (wr_en && wr_set == bus.rd_set && wr_way == WAY_W'(w)) begin
                    bus.valid_vector[w] <= 1'b1;
                    bus.dirty_vector[w] <= 1'b1;
                    bus.tag_vector[w]   <= wr_tag;
                    bus.data_vector[w]  <= wr_data;
                end else begin
                    bus.valid_vector[w] <= valid_mem[w][bus.rd_set];
                    bus.dirty_vector[w] <= dirty_mem[w][bus.rd_set];
                    bus.tag_vector[w]   <= tag_mem[w][bus.rd_set];
                    bus.data_vector[w]  <= data_mem[w][bus.rd_set];
                end
            end
        end
    end

endmodule

//--- host_write_port.sv
`timescale 1ns/100ps

module host_write_port (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      host_wr,
    input  mutative_types::set_addr_t host_set,
    input  mutative_types::way_idx_t  host_way,
    input  mutative_types::tag_t      host_tag,
    input  mutative_types::line_t     host_data,

    input  logic                      flush_stall,
    input  mutative_types::way_mask_t active_ways,
    output logic                      host_accept,

    output logic                      wr_en,
    output mutative_types::set_addr_t wr_set,
    output mutative_types::way_idx_t  wr_way,
    output mutative_types::tag_t      wr_tag,
    output mutative_types::line_t     wr_data
);

    logic take;

    // Refused while a flush walks the store or when the way is switched off
    assign host_accept = ~flush_stall & active_ways[host_way];
    assign take        = host_wr & host_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wr_set  <= host_set;
            wr_way  <= host_way;
            wr_tag  <= host_tag;
            wr_data <= host_data;
        end
    end

endmodule

//--- way_bus_if.sv
`timescale 1ns/100ps

interface way_bus_if #(
    parameter int WAYS     = mutative_types::WAYS,
    parameter int SET_SIZE = mutative_types::SET_SIZE
);

    localparam int SET_W = $clog2(SET_SIZE);
    localparam int WAY_W = $clog2(WAYS);

    // Read request, answered on the next cycle
    logic                  rd_en;
    logic [SET_W-1:0]      rd_set;

    // Contents of the set read last
    logic [WAYS-1:0]       valid_vector;
    logic [WAYS-1:0]       dirty_vector;
    mutative_types::tag_t  tag_vector  [WAYS];
    mutative_types::line_t data_vector [WAYS];

    // Clears one dirty bit
    logic                  clean_en;
    logic [SET_W-1:0]      clean_set;
    logic [WAY_W-1:0]      clean_way;

    modport store (
        input  rd_en, rd_set, clean_en, clean_set, clean_way,
        output valid_vector, dirty_vector, tag_vector, data_vector
    );

    modport user (
        output rd_en, rd_set, clean_en, clean_set, clean_way,
        input  valid_vector, dirty_vector, tag_vector, data_vector
    );

endinterface

//--- mutative_types.sv
package mutative_types;

    // Cache geometry
    localparam int WAYS           = 4;
    localparam int SET_SIZE       = 16;
    localparam int SET_BITS       = 4;
    localparam int OFFSET_BITS    = 5;
    localparam int TAG_BITS       = 32 - SET_BITS - OFFSET_BITS;
    localparam int CACHELINE_SIZE = 256;

    typedef logic [SET_BITS-1:0]       set_addr_t;

    // One bit wider so the walk can reach SET_SIZE
    typedef logic [SET_BITS:0]         flush_addr_t;

    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [CACHELINE_SIZE-1:0] line_t;
    typedef logic [WAYS-1:0]           way_mask_t;
    typedef logic [$clog2(WAYS)-1:0]   way_idx_t;

    // Level 0..3, active ways = 2**level
    typedef logic [1:0]                setup_t;

    typedef logic [31:0]               mem_addr_t;

endpackage
